// File: mlpClassifier.f
+incdir+design
+incdir+bench
design/mlpPkg.sv
design/reluNode.sv
design/denseLayer.sv
design/argmaxSelect.sv
design/mlpClassifier.sv
bench/mlpClassifierTb.sv

// File: bench/mlpModel.svh
// reference model of the network, built from the layer rules.
// the tables of mlpWeights.svh must already be in scope.

// 32-bit xorshift, shifts 13, 17 and 5.
function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// zero for negative words when clamping is on.
function automatic logic [31:0] reluIf(input logic [31:0] value, input bit clamp);
	logic [31:0] result;
	if (clamp && $signed(value) < 0)
	begin
		result = '0;
	end
	else
	begin
		result = value;
	end
	return result;
endfunction

// bias plus products, every step modulo 2^32.
function automatic mlpPkg::hiddenVec hiddenLayerRef(input mlpPkg::featureVec x,
	input bit clamp);
	mlpPkg::hiddenVec h;
	logic [31:0] acc;
	logic [31:0] term;
	for (int n = 0; n < mlpPkg::numHidden; n++)
	begin
		acc = hiddenBiases[n];
		for (int i = 0; i < mlpPkg::numFeatures; i++)
		begin
			term = x[i] * hiddenWeights[n][i]; // low word only.
			acc = acc + term;
		end
		h[n] = reluIf(acc, clamp);
	end
	return h;
endfunction

// output layer has no relu.
function automatic mlpPkg::scoreVec outputLayerRef(input mlpPkg::hiddenVec h);
	mlpPkg::scoreVec s;
	logic [31:0] acc;
	logic [31:0] term;
	for (int c = 0; c < mlpPkg::numClasses; c++)
	begin
		acc = outputBiases[c];
		for (int n = 0; n < mlpPkg::numHidden; n++)
		begin
			term = h[n] * outputWeights[c][n];
			acc = acc + term;
		end
		s[c] = acc;
	end
	return s;
endfunction

function automatic mlpPkg::scoreVec networkRef(input mlpPkg::featureVec x);
	return outputLayerRef(hiddenLayerRef(x, 1'b1));
endfunction

// largest signed score, earliest class on a tie.
function automatic mlpPkg::classIdx argmaxRef(input mlpPkg::scoreVec s);
	int best;
	best = 0;
	for (int c = 1; c < mlpPkg::numClasses; c++)
	begin
		if ($signed(s[c]) > $signed(s[best]))
		begin
			best = c;
		end
	end
	return mlpPkg::classIdx'(best);
endfunction

// File: bench/mlpClassifierTb.sv
`default_nettype none

module mlpClassifierTb;

	`include "mlpWeights.svh"
	`include "mlpModel.svh"

	localparam logic [31:0] seed = 32'hfb6a_3fb3;
	localparam int streamCount = 300;
	localparam int wideCount = 100;
	localparam int drainLimit = 4 * mlpPkg::networkLatency;

	logic clk;
	logic reset;
	mlpPkg::featureVec features;
	mlpPkg::scoreVec classScores;
	mlpPkg::classIdx classIndex;
	logic [mlpPkg::dataWidth-1:0] bestScore;

	logic [31:0] rngState;
	mlpPkg::featureVec history[$]; // samples still in the pipeline.
	int pushedCount;
	int checkedCount;
	int failures;

	mlpClassifier u_dut (
		.clk(clk),
		.reset(reset),
		.features(features),
		.classScores(classScores),
		.classIndex(classIndex),
		.bestScore(bestScore)
	);

	always #10 clk = ~clk;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch at time %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
			failures++;
			stopWithFailure("an output or model check did not match");
		end
	endtask

	task automatic expectZeroOutputs(input string when);
		for (int c = 0; c < mlpPkg::numClasses; c++)
		begin
			checkValue($sformatf("classScores[%0d] %s", c, when), classScores[c], '0);
		end
		checkValue($sformatf("classIndex %s", when), 32'(classIndex), '0);
		checkValue($sformatf("bestScore %s", when), bestScore, '0);
	endtask

	// drive on the rising edge and remember the sample.
	task automatic driveSample(input mlpPkg::featureVec sample);
		@(posedge clk);
		features <= sample;
		history.push_back(sample);
		pushedCount++;
	endtask

	// features within +-1024, products stay small.
	function automatic mlpPkg::featureVec smallSample();
		mlpPkg::featureVec x;
		for (int i = 0; i < mlpPkg::numFeatures; i++)
		begin
			rngState = xorshift32(rngState);
			x[i] = {{21{rngState[10]}}, rngState[10:0]};
		end
		return x;
	endfunction

	// full 32-bit range, products overflow.
	function automatic mlpPkg::featureVec wideSample();
		mlpPkg::featureVec x;
		for (int i = 0; i < mlpPkg::numFeatures; i++)
		begin
			rngState = xorshift32(rngState);
			x[i] = rngState;
		end
		return x;
	endfunction

	// every feature opposes the sign of its weight in one hidden node.
	function automatic mlpPkg::featureVec clampSample(input int node);
		mlpPkg::featureVec x;
		for (int i = 0; i < mlpPkg::numFeatures; i++)
		begin
			if ($signed(hiddenWeights[node][i]) < 0)
			begin
				x[i] = 32'd10000;
			end
			else
			begin
				x[i] = -32'sd10000;
			end
		end
		return x;
	endfunction

	// outputs sampled at the falling edge, away from the drive edge.
	always @(negedge clk)
	begin : compareOutputs
		mlpPkg::featureVec sample;
		mlpPkg::scoreVec expScores;
		mlpPkg::classIdx expIndex;
		if (!reset && history.size() > mlpPkg::networkLatency)
		begin
			sample = history.pop_front();
			expScores = networkRef(sample);
			expIndex = argmaxRef(expScores);
			for (int c = 0; c < mlpPkg::numClasses; c++)
			begin
				checkValue($sformatf("classScores[%0d]", c), classScores[c], expScores[c]);
			end
			checkValue("classIndex", 32'(classIndex), 32'(expIndex));
			checkValue("bestScore", bestScore, expScores[expIndex]);
			checkedCount++;
		end
	end

	initial
	begin : mainSequence
		mlpPkg::featureVec sample;
		mlpPkg::hiddenVec rawHidden;
		mlpPkg::scoreVec clamped;
		mlpPkg::scoreVec unclamped;
		mlpPkg::scoreVec zeroScores;
		int target;
		int waitCycles;
		clk = 1'b0;
		reset = 1'b1;
		features = '0;
		rngState = seed;
		pushedCount = 0;
		checkedCount = 0;
		failures = 0;

		repeat (3)
		begin
			@(posedge clk);
			@(negedge clk);
			expectZeroOutputs("during reset");
		end
		// fourth reset edge, release and start the zero fill.
		driveSample('0);
		reset <= 1'b0;
		@(negedge clk);
		expectZeroOutputs("at reset release");
		driveSample('0);
		@(negedge clk);
		expectZeroOutputs("one cycle after reset");
		repeat (5) driveSample('0);

		for (int k = 0; k < streamCount; k++)
		begin
			driveSample(smallSample());
		end

		for (int n = 0; n < mlpPkg::numHidden; n++)
		begin
			sample = clampSample(n);
			rawHidden = hiddenLayerRef(sample, 1'b0);
			checkValue($sformatf("hidden node %0d sum sign", n),
				rawHidden[n][mlpPkg::dataWidth-1], 1);
			clamped = outputLayerRef(hiddenLayerRef(sample, 1'b1));
			unclamped = outputLayerRef(rawHidden);
			checkValue($sformatf("clamp effect on node %0d", n), clamped != unclamped, 1);
			driveSample(sample);
		end

		// zero sample ties classes 0 and 1.
		zeroScores = networkRef('0);
		checkValue("tie of class 1 with class 0", zeroScores[1], zeroScores[0]);
		driveSample('0);

		for (int k = 0; k < wideCount; k++)
		begin
			driveSample(wideSample());
		end

		// padding zeros push the last samples out.
		target = pushedCount;
		waitCycles = 0;
		while (checkedCount < target)
		begin
			driveSample('0);
			waitCycles++;
			if (waitCycles > drainLimit)
			begin
				stopWithFailure("timed out waiting for the last samples to leave the pipeline");
			end
		end
		@(negedge clk);

		if (failures == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			stopWithFailure("checks failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: design/mlpClassifier.sv
`default_nettype none

module mlpClassifier (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVec features,
	output mlpPkg::scoreVec classScores,
	output mlpPkg::classIdx classIndex,
	output logic [mlpPkg::dataWidth-1:0] bestScore
);

	`include "mlpWeights.svh"

	mlpPkg::hiddenVec hiddenActs;
	mlpPkg::scoreVec layerScores;

	// hidden layer, relu on.
	denseLayer #(
		.numInputs(mlpPkg::numFeatures),
		.numNodes(mlpPkg::numHidden),
		.weights(hiddenWeights),
		.biases(hiddenBiases),
		.applyRelu(1'b1)
	) u_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.activations(features),
		.results(hiddenActs)
	);

	// output layer gives raw scores.
	denseLayer #(
		.numInputs(mlpPkg::numHidden),
		.numNodes(mlpPkg::numClasses),
		.weights(outputWeights),
		.biases(outputBiases),
		.applyRelu(1'b0)
	) u_outputLayer (
		.clk(clk),
		.reset(reset),
		.activations(hiddenActs),
		.results(layerScores)
	);

	argmaxSelect #(
		.numCandidates(mlpPkg::numClasses)
	) u_argmax (
		.clk(clk),
		.reset(reset),
		.scores(layerScores),
		.classScores(classScores),
		.classIndex(classIndex),
		.bestScore(bestScore)
	);

endmodule

`default_nettype wire

// File: design/argmaxSelect.sv
`default_nettype none

module argmaxSelect #(
	parameter int numCandidates = 3
) (
	input logic clk,
	input logic reset,
	input logic [numCandidates-1:0][mlpPkg::dataWidth-1:0] scores,
	output mlpPkg::scoreVec classScores,
	output mlpPkg::classIdx classIndex,
	output logic [mlpPkg::dataWidth-1:0] bestScore
);

	mlpPkg::classIdx bestIdx;
	logic [mlpPkg::dataWidth-1:0] bestVal;

	// output vector is sized by the package.
	if (numCandidates != mlpPkg::numClasses)
	begin : candidateCheck
		$error("argmaxSelect: %0d candidates but %0d classes",
			numCandidates, mlpPkg::numClasses);
	end

	// strict signed compare so ties keep the lowest index.
	always_comb
	begin
		bestIdx = '0;
		bestVal = scores[0];
		for (int i = 1; i < numCandidates; i++)
		begin
			if ($signed(scores[i]) > $signed(bestVal))
			begin
				bestIdx = mlpPkg::classIdx'(i);
				bestVal = scores[i];
			end
		end
	end

	// scores, index and winner registered together.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classScores <= '0;
			classIndex <= '0;
			bestScore <= '0;
		end
		else
		begin
			classScores <= scores;
			classIndex <= bestIdx;
			bestScore <= bestVal;
		end
	end

	indexInRange: assert property (
		@(posedge clk) disable iff (reset)
		classIndex < numCandidates
	)
	else
		$error("argmaxSelect: class index %0d out of range", classIndex);

endmodule

`default_nettype wire

// File: design/denseLayer.sv
`default_nettype none

module denseLayer #(
	parameter int numInputs = 10,
	parameter int numNodes = 4,
	parameter logic [0:numNodes-1][0:numInputs-1][mlpPkg::dataWidth-1:0] weights = '0,
	parameter logic [0:numNodes-1][mlpPkg::dataWidth-1:0] biases = '0,
	parameter bit applyRelu = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic [numInputs-1:0][mlpPkg::dataWidth-1:0] activations,
	output logic [numNodes-1:0][mlpPkg::dataWidth-1:0] results
);

	// table shape must agree with the layer shape.
	if ($size(weights, 1) * $size(weights, 2) != numNodes * numInputs)
	begin : weightShapeCheck
		$error("denseLayer: weight table has %0d entries, expected %0d",
			$size(weights, 1) * $size(weights, 2), numNodes * numInputs);
	end

	// all nodes see the same input vector and run in lockstep.
	for (genvar n = 0; n < numNodes; n++)
	begin : nodeGen
		reluNode #(
			.numInputs(numInputs),
			.weights(weights[n]), // row n.
			.bias(biases[n]),
			.applyRelu(applyRelu)
		) u_node (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.activation(results[n])
		);
	end

endmodule

`default_nettype wire

// File: design/reluNode.sv
`default_nettype none

module reluNode #(
	parameter int numInputs = 10,
	parameter logic [0:numInputs-1][mlpPkg::dataWidth-1:0] weights = '0,
	parameter logic [mlpPkg::dataWidth-1:0] bias = '0,
	parameter bit applyRelu = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic [numInputs-1:0][mlpPkg::dataWidth-1:0] activations,
	output logic [mlpPkg::dataWidth-1:0] activation
);

	logic [numInputs-1:0][mlpPkg::dataWidth-1:0] capturedActs;
	logic [numInputs-1:0][mlpPkg::dataWidth-1:0] products;
	logic [mlpPkg::dataWidth-1:0] weightedSum;
	logic [mlpPkg::dataWidth-1:0] sumReg;
	logic clampSum;

	// stage 1, input capture.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			capturedActs <= '0;
		end
		else
		begin
			capturedActs <= activations;
		end
	end

	// low word of each product only.
	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
		begin
			products[i] = capturedActs[i] * weights[i];
		end
	end

	always_comb
	begin
		weightedSum = bias;
		for (int i = 0; i < numInputs; i++)
		begin
			weightedSum = weightedSum + products[i]; // wraps.
		end
	end

	// stage 2, registered sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= weightedSum;
		end
	end

	// negative sums go to zero on relu nodes.
	assign clampSum = applyRelu && sumReg[mlpPkg::dataWidth-1];

	// stage 3, activation.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (clampSum)
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg;
		end
	end

	// a relu node never hands a negative value downstream.
	reluNonNegative: assert property (
		@(posedge clk) (applyRelu && !reset) |=> !activation[mlpPkg::dataWidth-1]
	)
	else
		$error("reluNode: negative activation %0h out of a relu node", activation);

endmodule

`default_nettype wire

// File: design/mlpPkg.sv
`default_nettype none

package mlpPkg;

	// every activation, weight and bias is one word.
	localparam int dataWidth = 32;

	// network shape.
	localparam int numFeatures = 10;
	localparam int numHidden = 4;
	localparam int numClasses = 3;

	// register stages inside one node: capture, sum, activation.
	localparam int nodeLatency = 3;

	// two dense layers plus the argmax register.
	localparam int networkLatency = 2 * nodeLatency + 1;

	// one input sample, element i is feature i.
	typedef logic [numFeatures-1:0][dataWidth-1:0] featureVec;

	// hidden layer outputs.
	typedef logic [numHidden-1:0][dataWidth-1:0] hiddenVec;

	// raw class scores out of the output layer.
	typedef logic [numClasses-1:0][dataWidth-1:0] scoreVec;

	typedef logic [$clog2(numClasses)-1:0] classIdx;

endpackage

`default_nettype wire

// File: design/mlpWeights.svh
// fixed network tables, element [n][i] weights input i of node n.
// values wrap modulo 2^32 like the datapath.

localparam logic [0:mlpPkg::numHidden-1][0:mlpPkg::numFeatures-1][mlpPkg::dataWidth-1:0]
	hiddenWeights = '{
		'{-7609, 3011, 4685, -816, -463, -5893, -992, -2227, -4183, -658},
		'{2514, -1186, 3307, 5120, -2749, 871, -4402, 1968, 605, -3371},
		'{-1432, 6018, -2295, 1177, 3846, -5310, 2751, -689, -1904, 4433},
		'{3920, 1245, -3566, -2081, 5527, 1093, -768, 4116, -2938, 1650}
	};

// node 1 bias is negative, so a zero sample clamps it.
localparam logic [0:mlpPkg::numHidden-1][mlpPkg::dataWidth-1:0]
	hiddenBiases = '{
		120,
		-50,
		0,
		35
	};

localparam logic [0:mlpPkg::numClasses-1][0:mlpPkg::numHidden-1][mlpPkg::dataWidth-1:0]
	outputWeights = '{
		'{2113, -3870, 1502, -944},
		'{1450, 2987, -1201, 3518},
		'{-2702, 1823, 4096, -1377}
	};

// with a zero sample classes 0 and 1 both score 297000.
// class 2 lands at -371923.
localparam logic [0:mlpPkg::numClasses-1][mlpPkg::dataWidth-1:0]
	outputBiases = '{
		76480,
		-130,
		512
	};
